// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_gb_timer
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
verilog/gb_bus_pkg.sv
verilog/gb_timer_pkg.sv
verilog/timer_ctrl_if.sv
verilog/clock_phase_gen.sv
verilog/div_counter.sv
verilog/timer_regs.sv
verilog/timer_core.sv
verilog/gb_timer_top.sv
testbench/tb_gb_timer.sv

// ==== testbench/tb_gb_timer.sv ====
`timescale 1ns/1ps

module tb_gb_timer;

	import gb_bus_pkg::*;

	localparam int RESET_HOLD = 4;
	localparam int MAX_CYCLES = 120000; // The tests need roughly 55000

	logic        clkin_a;
	logic        rst_n;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_wr;
	logic        cpu_rd;
	logic [7:0]  cpu_rdata;
	logic        cpu_rd_hit;
	logic        timer_irq;
	logic        apu_frame_tick;
	logic        phi_out;

	integer      seed = 32'hb538e94f;
	int          errors = 0;
	int          cycles = 0;
	int          hold_cnt = 0;
	logic [15:0] ref_div = '0;
	int          irq_count = 0;
	int          frame_count = 0;
	int          phi_rises = 0;
	logic        phi_q = 1'b0;

	gb_timer_top #(
		.RESET_HOLD(RESET_HOLD)
	) u_gb_timer_top (
		.clkin_a        (clkin_a),
		.rst_n          (rst_n),
		.cpu_addr       (cpu_addr),
		.cpu_wdata      (cpu_wdata),
		.cpu_wr         (cpu_wr),
		.cpu_rd         (cpu_rd),
		.cpu_rdata      (cpu_rdata),
		.cpu_rd_hit     (cpu_rd_hit),
		.timer_irq      (timer_irq),
		.apu_frame_tick (apu_frame_tick),
		.phi_out        (phi_out)
	);

	initial begin
		clkin_a = 1'b0;
		forever #4 clkin_a = ~clkin_a;
	end

	// Reference divider, held while reset is stretched
	always @(posedge clkin_a) begin
		if (!rst_n) begin
			ref_div  <= '0;
			hold_cnt <= 0;
		end else if (hold_cnt < RESET_HOLD) begin
			hold_cnt <= hold_cnt + 1;
		end else if (cpu_wr && cpu_addr == ADDR_DIV) begin
			ref_div <= '0;
		end else begin
			ref_div <= ref_div + 16'd1;
		end
	end

	// Pulse and edge counters, sampled on the rising edge
	always @(posedge clkin_a) begin
		phi_q <= phi_out;
		if (timer_irq)
			irq_count <= irq_count + 1;
		if (apu_frame_tick)
			frame_count <= frame_count + 1;
		if (phi_out && !phi_q)
			phi_rises <= phi_rises + 1;
	end

	always @(posedge clkin_a) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors: %0d, cycles run: %0d", errors, cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input int got, input int expected);
		$display("Mismatch %s: got %0h, expected %0h", name, got, expected);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("Error: %s", what);
		errors++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clkin_a);
			cpu_rd = 1'b0;
			cpu_wr = 1'b0;
		end
	endtask

	task automatic write_reg(input addr_t addr, input data_t data);
		@(negedge clkin_a);
		cpu_rd    = 1'b0;
		cpu_addr  = addr;
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		@(negedge clkin_a);
		cpu_wr = 1'b0;
	endtask

	// Read data is combinational, so it is sampled inside the same cycle
	task automatic read_reg(input addr_t addr, output data_t data, output logic hit);
		@(negedge clkin_a);
		cpu_wr   = 1'b0;
		cpu_addr = addr;
		cpu_rd   = 1'b1;
		#2;
		data = cpu_rdata;
		hit  = cpu_rd_hit;
	endtask

	// Disable counting and clear TIMA, then let any pending reload finish
	task automatic quiet_timer();
		write_reg(ADDR_TAC, 8'h01);
		write_reg(ADDR_TIMA, 8'h00);
		idle(8);
	endtask

	task automatic test_reset_values();
		data_t d;
		logic  h;
		idle(RESET_HOLD + 2);
		read_reg(ADDR_DIV, d, h);
		if (d !== 8'h00) report_mismatch("DIV", d, 8'h00);
		if (h !== 1'b1) report_mismatch("cpu_rd_hit", h, 1);
		read_reg(ADDR_TIMA, d, h);
		if (d !== 8'h00) report_mismatch("TIMA", d, 8'h00);
		read_reg(ADDR_TMA, d, h);
		if (d !== 8'h00) report_mismatch("TMA", d, 8'h00);
		read_reg(ADDR_TAC, d, h);
		if (d !== 8'hF8) report_mismatch("TAC", d, 8'hF8);
		read_reg(16'hFF03, d, h);
		if (d !== 8'hFF) report_mismatch("cpu_rdata", d, 8'hFF);
		if (h !== 1'b0) report_mismatch("cpu_rd_hit", h, 0);
		read_reg(16'hFF08, d, h);
		if (h !== 1'b0) report_mismatch("cpu_rd_hit", h, 0);
		if (timer_irq !== 1'b0) report_mismatch("timer_irq", timer_irq, 0);
	endtask

	task automatic test_div_reads();
		int    rnd;
		data_t d;
		logic  h;
		write_reg(ADDR_DIV, 8'h00);
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			idle(50 + (rnd & 1023));
			read_reg(ADDR_DIV, d, h);
			if (d !== ref_div[15:8]) report_mismatch("DIV", d, ref_div[15:8]);
		end
		write_reg(ADDR_DIV, 8'h5A); // The written value is ignored
		read_reg(ADDR_DIV, d, h);
		if (d !== 8'h00) report_mismatch("DIV", d, 8'h00);
		idle(300);
		read_reg(ADDR_DIV, d, h);
		if (d !== ref_div[15:8]) report_mismatch("DIV", d, ref_div[15:8]);
	endtask

	// TIMA may lag the ideal count by one because of the edge detector
	task automatic measure_rate(input logic [1:0] sel, input int period, input int step);
		data_t d;
		logic  h;
		data_t expected;
		data_t lag;
		quiet_timer();
		write_reg(ADDR_TMA, 8'h00);
		write_reg(ADDR_TAC, {5'b00000, 1'b1, sel});
		write_reg(ADDR_DIV, 8'h00);
		write_reg(ADDR_TIMA, 8'h00);
		repeat (4) begin
			idle(step);
			read_reg(ADDR_TIMA, d, h);
			expected = data_t'((int'(ref_div) / period) % 256);
			lag = expected - d;
			if (lag > 8'd1) report_mismatch("TIMA", d, expected);
		end
	endtask

	task automatic test_disabled();
		data_t d;
		data_t t1;
		logic  h;
		write_reg(ADDR_TAC, 8'h01);
		read_reg(ADDR_TAC, d, h);
		if (d !== 8'hF9) report_mismatch("TAC", d, 8'hF9);
		read_reg(ADDR_TIMA, t1, h);
		idle(600);
		read_reg(ADDR_TIMA, d, h);
		if (d !== t1) report_mismatch("TIMA", d, t1);
	endtask

	task automatic test_overflow();
		int    rnd;
		int    polls;
		int    irq_start;
		data_t tma_val;
		data_t d;
		logic  h;
		quiet_timer();
		rnd = $random(seed);
		tma_val = rnd[7:0];
		write_reg(ADDR_TMA, tma_val);
		read_reg(ADDR_TMA, d, h);
		if (d !== tma_val) report_mismatch("TMA", d, tma_val);
		irq_start = irq_count;
		write_reg(ADDR_TAC, 8'h05);
		write_reg(ADDR_DIV, 8'h00);
		write_reg(ADDR_TIMA, 8'hFF);
		d = 8'hFF;
		polls = 0;
		while (d === 8'hFF && polls < 64) begin
			read_reg(ADDR_TIMA, d, h);
			polls++;
		end
		if (d !== 8'h00) report_mismatch("TIMA", d, 8'h00);
		if (irq_count != irq_start) report_failure("timer_irq fired before the reload delay ended");
		polls = 0;
		while (irq_count == irq_start && polls < 32) begin
			idle(1);
			polls++;
		end
		if (irq_count == irq_start) report_failure("timer_irq did not pulse after TIMA overflow");
		read_reg(ADDR_TIMA, d, h);
		if (d !== tma_val) report_mismatch("TIMA", d, tma_val);
		idle(6);
		if (irq_count != irq_start + 1) report_mismatch("timer_irq pulses", irq_count - irq_start, 1);

		// Same wrap again, but TIMA is written while the reload is pending
		quiet_timer();
		irq_start = irq_count;
		write_reg(ADDR_TAC, 8'h05);
		write_reg(ADDR_DIV, 8'h00);
		write_reg(ADDR_TIMA, 8'hFF);
		d = 8'hFF;
		polls = 0;
		while (d === 8'hFF && polls < 64) begin
			read_reg(ADDR_TIMA, d, h);
			polls++;
		end
		if (d !== 8'h00) report_mismatch("TIMA", d, 8'h00);
		write_reg(ADDR_TIMA, 8'h42);
		read_reg(ADDR_TIMA, d, h);
		if (d !== 8'h42) report_mismatch("TIMA", d, 8'h42);
		idle(24);
		if (irq_count != irq_start)
			report_failure("timer_irq fired although TIMA was written during the reload delay");
	endtask

	task automatic test_div_glitch();
		data_t t0;
		data_t d;
		logic  h;
		quiet_timer();
		write_reg(ADDR_TIMA, 8'h10);
		write_reg(ADDR_TAC, 8'h05);
		do
			@(negedge clkin_a);
		while (ref_div[3:0] != 4'd6);
		read_reg(ADDR_TIMA, t0, h); // Count is 7 here, so the DIV write lands at 8
		write_reg(ADDR_DIV, 8'h00);
		read_reg(ADDR_TIMA, d, h);
		if (d !== data_t'(t0 + 8'd1)) report_mismatch("TIMA", d, data_t'(t0 + 8'd1));
	endtask

	task automatic test_frame_and_phase();
		int start;
		write_reg(ADDR_DIV, 8'h00);
		write_reg(ADDR_DIV, 8'h00); // Second clear starts with bit 12 low
		start = frame_count;
		idle(3 * 8192 + 16);
		if (frame_count - start != 3)
			report_mismatch("apu_frame_tick pulses", frame_count - start, 3);
		for (int k = 0; k < 3; k++) begin
			idle(k + 1);
			start = phi_rises;
			idle(16);
			if (phi_rises - start != 4)
				report_mismatch("phi_out rising edges", phi_rises - start, 4);
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_wr    = 1'b0;
		cpu_rd    = 1'b0;
		repeat (2) @(posedge clkin_a);
		@(negedge clkin_a);
		rst_n = 1'b1;

		test_reset_values();
		test_div_reads();
		measure_rate(2'd1, 16, 1370);
		measure_rate(2'd2, 64, 4300);
		test_disabled();
		test_overflow();
		test_div_glitch();
		test_frame_and_phase();

		$display("Errors: %0d, cycles run: %0d", errors, cycles);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== verilog/clock_phase_gen.sv ====
`timescale 1ns/1ps

module clock_phase_gen #(
	parameter int RESET_HOLD = 4
) (
	input  logic clkin_a,
	input  logic rst_n,
	output logic nreset_sys,
	output logic m_tick,
	output logic phi_out
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic [1:0]        phase;

	// Reset is only released after a run of clean clocks
	always_ff @(posedge clkin_a) begin
		if (!rst_n) begin
			hold_cnt   <= '0;
			nreset_sys <= 1'b0;
		end else if (!nreset_sys) begin
			if (hold_cnt == HOLD_W'(RESET_HOLD - 1))
				nreset_sys <= 1'b1;
			else
				hold_cnt <= hold_cnt + 1'b1;
		end
	end

	// T-cycle position inside the current M-cycle
	always_ff @(posedge clkin_a) begin
		if (!nreset_sys)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	assign m_tick  = (phase == 2'd3); // Last T-cycle of each M-cycle
	assign phi_out = phase[1];        // Half the M-cycle high, half low

	a_m_tick_single: assert property (
		@(posedge clkin_a) disable iff (!nreset_sys)
		m_tick |=> !m_tick
	) else $error("m_tick high on consecutive clocks");

endmodule

// ==== verilog/div_counter.sv ====
`timescale 1ns/1ps

module div_counter (
	input  logic               clkin_a,
	input  logic               nreset_sys,
	input  logic               div_clear,
	output gb_timer_pkg::div_t div_count,
	output logic               apu_frame_tick
);

	import gb_timer_pkg::*;

	logic frame_bit_q;

	// Free-running, any write to FF04 zeroes the whole count
	always_ff @(posedge clkin_a) begin
		if (!nreset_sys || div_clear)
			div_count <= '0;
		else
			div_count <= div_count + 16'd1;
	end

	always_ff @(posedge clkin_a) begin
		if (!nreset_sys)
			frame_bit_q <= 1'b0;
		else
			frame_bit_q <= div_count[FRAME_BIT];
	end

	// A clear while the bit is set also produces a step
	assign apu_frame_tick = frame_bit_q & ~div_count[FRAME_BIT];

endmodule

// ==== verilog/gb_bus_pkg.sv ====
package gb_bus_pkg;

	// CPU side of the register window
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Timer block registers in the I/O page
	localparam addr_t ADDR_DIV  = 16'hFF04;
	localparam addr_t ADDR_TIMA = 16'hFF05;
	localparam addr_t ADDR_TMA  = 16'hFF06;
	localparam addr_t ADDR_TAC  = 16'hFF07;

	localparam data_t DATA_UNMAPPED = 8'hFF; // Open bus reads back all ones

endpackage

// ==== verilog/gb_timer_pkg.sv ====
package gb_timer_pkg;

	typedef logic [15:0] div_t;

	// TAC as seen on the bus, MSB first
	typedef struct packed {
		logic [4:0] unused; // Not implemented, reads as ones
		logic       enable;
		logic [1:0] sel;
	} tac_t;

	localparam tac_t TAC_RESET = '{unused: 5'b11111, enable: 1'b0, sel: 2'd0};

	// Divider bit feeding TIMA for each clock select
	// 0 is 4096 Hz, 1 is 262144 Hz, 2 is 65536 Hz, 3 is 16384 Hz
	localparam int TAP_BIT [4] = '{9, 3, 5, 7};

	// Falling edge of this bit gives the 512 Hz sequencer step
	localparam int FRAME_BIT = 12;

	// Clocks that TIMA sits at zero after wrapping
	localparam int RELOAD_DELAY = 4;

endpackage

// ==== verilog/gb_timer_top.sv ====
`timescale 1ns/1ps

module gb_timer_top #(
	parameter int RESET_HOLD = 4
) (
	input  logic        clkin_a,
	input  logic        rst_n,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_wr,
	input  logic        cpu_rd,
	output logic [7:0]  cpu_rdata,
	output logic        cpu_rd_hit,
	output logic        timer_irq,
	output logic        apu_frame_tick,
	output logic        phi_out
);

	import gb_timer_pkg::*;

	logic nreset_sys;
	logic m_tick;
	logic div_clear;
	div_t div_count;

	timer_ctrl_if u_ctrl_if ();

	clock_phase_gen #(
		.RESET_HOLD(RESET_HOLD)
	) u_clock_phase_gen (
		.clkin_a    (clkin_a),
		.rst_n      (rst_n),
		.nreset_sys (nreset_sys),
		.m_tick     (m_tick),
		.phi_out    (phi_out)
	);

	div_counter u_div_counter (
		.clkin_a        (clkin_a),
		.nreset_sys     (nreset_sys),
		.div_clear      (div_clear),
		.div_count      (div_count),
		.apu_frame_tick (apu_frame_tick)
	);

	timer_regs u_timer_regs (
		.clkin_a    (clkin_a),
		.nreset_sys (nreset_sys),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_wr     (cpu_wr),
		.cpu_rd     (cpu_rd),
		.cpu_rdata  (cpu_rdata),
		.cpu_rd_hit (cpu_rd_hit),
		.div_count  (div_count),
		.div_clear  (div_clear),
		.ctrl       (u_ctrl_if.regs)
	);

	timer_core u_timer_core (
		.clkin_a    (clkin_a),
		.nreset_sys (nreset_sys),
		.div_count  (div_count),
		.m_tick     (m_tick),
		.ctrl       (u_ctrl_if.core),
		.timer_irq  (timer_irq)
	);

endmodule

// ==== verilog/timer_core.sv ====
`timescale 1ns/1ps

module timer_core (
	input  logic               clkin_a,
	input  logic               nreset_sys,
	input  gb_timer_pkg::div_t div_count,
	input  logic               m_tick,
	timer_ctrl_if.core         ctrl,
	output logic               timer_irq
);

	import gb_bus_pkg::*;
	import gb_timer_pkg::*;

	localparam int CNT_W = $clog2(RELOAD_DELAY + 1);

	logic             tap_level;
	logic             tap_q;
	logic             tima_inc;
	data_t            tima_q;
	data_t            tma_q;
	data_t            tma_next;
	logic             reload_pend;
	logic [CNT_W-1:0] reload_cnt;
	logic             reload_now;

	// Clearing DIV or TAC.enable while the tap is high also looks like a fall
	assign tap_level = div_count[TAP_BIT[ctrl.tac.sel]] & ctrl.tac.enable;
	assign tima_inc  = tap_q & ~tap_level;

	assign reload_now = reload_pend && (reload_cnt == CNT_W'(RELOAD_DELAY - 1));
	assign tma_next   = ctrl.tma_wr ? ctrl.wdata : tma_q; // Same-edge TMA write is seen

	always_ff @(posedge clkin_a) begin
		if (!nreset_sys) begin
			tap_q       <= 1'b0;
			tima_q      <= '0;
			tma_q       <= '0;
			reload_pend <= 1'b0;
			reload_cnt  <= '0;
			timer_irq   <= 1'b0;
		end else begin
			tap_q     <= tap_level;
			tma_q     <= tma_next;
			timer_irq <= 1'b0;
			if (reload_now) begin
				tima_q      <= tma_next;
				reload_pend <= 1'b0;
				timer_irq   <= 1'b1;
			end else if (ctrl.tima_wr) begin
				tima_q      <= ctrl.wdata; // Also drops a pending reload
				reload_pend <= 1'b0;
			end else if (reload_pend) begin
				reload_cnt <= reload_cnt + 1'b1; // TIMA holds 00 meanwhile
			end else if (tima_inc) begin
				tima_q <= tima_q + 8'd1;
				if (tima_q == 8'hFF) begin
					reload_pend <= 1'b1;
					reload_cnt  <= '0;
				end
			end
		end
	end

	assign ctrl.tima = tima_q;
	assign ctrl.tma  = tma_q;

	a_irq_one_clock: assert property (
		@(posedge clkin_a) disable iff (!nreset_sys)
		timer_irq |=> !timer_irq
	) else $error("timer_irq longer than one clock");

endmodule

// ==== verilog/timer_ctrl_if.sv ====
`timescale 1ns/1ps

interface timer_ctrl_if;
	import gb_bus_pkg::*;
	import gb_timer_pkg::*;

	logic  tima_wr; // One clock, on the write edge
	logic  tma_wr;
	data_t wdata;
	tac_t  tac;
	data_t tima;
	data_t tma;

	modport regs (
		output tima_wr,
		output tma_wr,
		output wdata,
		output tac,
		input  tima,
		input  tma
	);

	modport core (
		input  tima_wr,
		input  tma_wr,
		input  wdata,
		input  tac,
		output tima,
		output tma
	);

endinterface

// ==== verilog/timer_regs.sv ====
`timescale 1ns/1ps

module timer_regs (
	input  logic               clkin_a,
	input  logic               nreset_sys,
	input  gb_bus_pkg::addr_t  cpu_addr,
	input  gb_bus_pkg::data_t  cpu_wdata,
	input  logic               cpu_wr,
	input  logic               cpu_rd,
	output gb_bus_pkg::data_t  cpu_rdata,
	output logic               cpu_rd_hit,
	input  gb_timer_pkg::div_t div_count,
	output logic               div_clear,
	timer_ctrl_if.regs         ctrl
);

	import gb_bus_pkg::*;
	import gb_timer_pkg::*;

	logic sel_div;
	logic sel_tima;
	logic sel_tma;
	logic sel_tac;
	logic in_window;
	tac_t tac_q;

	assign sel_div   = (cpu_addr == ADDR_DIV);
	assign sel_tima  = (cpu_addr == ADDR_TIMA);
	assign sel_tma   = (cpu_addr == ADDR_TMA);
	assign sel_tac   = (cpu_addr == ADDR_TAC);
	assign in_window = sel_div | sel_tima | sel_tma | sel_tac;

	// Strobes act on the same edge that samples cpu_wr
	assign div_clear    = cpu_wr & sel_div;
	assign ctrl.tima_wr = cpu_wr & sel_tima;
	assign ctrl.tma_wr  = cpu_wr & sel_tma;
	assign ctrl.wdata   = cpu_wdata;

	// Only enable and select are writable
	always_ff @(posedge clkin_a) begin
		if (!nreset_sys) begin
			tac_q <= TAC_RESET;
		end else if (cpu_wr && sel_tac) begin
			tac_q.enable <= cpu_wdata[2];
			tac_q.sel    <= cpu_wdata[1:0];
		end
	end

	assign ctrl.tac = tac_q;

	assign cpu_rd_hit = cpu_rd & in_window;

	always_comb begin
		cpu_rdata = DATA_UNMAPPED;
		if (cpu_rd_hit) begin
			case (1'b1)
				sel_div:  cpu_rdata = div_count[15:8]; // Upper byte only
				sel_tima: cpu_rdata = ctrl.tima;
				sel_tma:  cpu_rdata = ctrl.tma;
				default:  cpu_rdata = data_t'(tac_q);
			endcase
		end
	end

	// The CPU issues one access per M-cycle, never both
	a_no_rd_wr: assert property (
		@(posedge clkin_a) disable iff (!nreset_sys)
		!(cpu_rd && cpu_wr)
	) else $error("cpu_rd and cpu_wr asserted together");

endmodule
